// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_cad
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_cad.sv ====
`timescale 1ns/10ps

module tb_cad;

  localparam int IMG_SIDE = 8;
  localparam int IMG_COUNT = 2;
  localparam int KER_COUNT = 2;
  localparam int IMG_IDX_W = (IMG_COUNT > 1) ? $clog2(IMG_COUNT) : 1;
  localparam int KER_IDX_W = (KER_COUNT > 1) ? $clog2(KER_COUNT) : 1;
  localparam int KER_SIDE = 5;
  localparam int IMG_SZ = IMG_SIDE * IMG_SIDE;
  localparam int BLK_SIDE = (IMG_SIDE - KER_SIDE + 1) / 2;
  localparam int POOLS = BLK_SIDE * BLK_SIDE;
  localparam int RES_W = 20;
  localparam int BUSY_LIMIT = POOLS * 40 + 100;

  logic clk;
  logic rst_n;
  logic i_in_valid;
  logic [7:0] i_matrix;
  logic i_start;
  logic [IMG_IDX_W-1:0] i_img_idx;
  logic [KER_IDX_W-1:0] i_ker_idx;
  logic o_busy;
  logic o_out_valid;
  logic o_out_value;

  // model copies of the loaded operands
  int img_model[IMG_COUNT][IMG_SZ];
  int ker_model[KER_COUNT][KER_SIDE*KER_SIDE];
  logic [RES_W-1:0] exp_q[$];
  logic [15:0] lfsr;
  logic [RES_W-1:0] rx_word;
  int rx_bits;
  int run_len;
  int res_seen;

  cad_top #(
    .IMG_SIDE (IMG_SIDE),
    .IMG_COUNT(IMG_COUNT),
    .KER_COUNT(KER_COUNT)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_in_valid (i_in_valid),
    .i_matrix   (i_matrix),
    .i_start    (i_start),
    .i_img_idx  (i_img_idx),
    .i_ker_idx  (i_ker_idx),
    .o_busy     (o_busy),
    .o_out_valid(o_out_valid),
    .o_out_value(o_out_value)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_error($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  // max of the four 5x5 sums in pool block (br, bc)
  function automatic logic [RES_W-1:0] pooled_max(input int img, input int ker,
                                                  input int br, input int bc);
    int best;
    int sum;
    int r0;
    int c0;
    best = 0;
    for (int dr = 0; dr < 2; dr++) begin
      for (int dc = 0; dc < 2; dc++) begin
        r0 = 2 * br + dr;
        c0 = 2 * bc + dc;
        sum = 0;
        for (int kr = 0; kr < KER_SIDE; kr++) begin
          for (int kc = 0; kc < KER_SIDE; kc++) begin
            sum += img_model[img][(r0 + kr) * IMG_SIDE + c0 + kc]
                 * ker_model[ker][kr * KER_SIDE + kc];
          end
        end
        if ((dr == 0 && dc == 0) || sum > best) begin
          best = sum;
        end
      end
    end
    return best[RES_W-1:0];
  endfunction

  task automatic send_value(input logic [7:0] v);
    @(posedge clk);
    i_in_valid <= 1'b1;
    i_matrix <= v;
  endtask

  // mode 0 is random, 1 gives low pixels with high kernels and 2 the reverse
  task automatic load_operands(input int mode);
    logic [7:0] v;
    for (int m = 0; m < IMG_COUNT; m++) begin
      for (int e = 0; e < IMG_SZ; e++) begin
        if (mode == 0) begin
          v = rand_byte();
        end else begin
          v = (mode == 1) ? 8'h80 : 8'h7f;
        end
        img_model[m][e] = $signed(v);
        send_value(v);
      end
    end
    for (int k = 0; k < KER_COUNT; k++) begin
      for (int e = 0; e < KER_SIDE * KER_SIDE; e++) begin
        if (mode == 0) begin
          v = rand_byte();
        end else begin
          v = (mode == 1) ? 8'h7f : 8'h80;
        end
        ker_model[k][e] = $signed(v);
        send_value(v);
      end
    end
    @(posedge clk);
    i_in_valid <= 1'b0;
    i_matrix <= '0;
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (o_busy !== level && n < limit);
    if (o_busy !== level) begin
      report_error($sformatf("o_busy did not go to %0d within %0d cycles", level, limit));
    end
  endtask

  task automatic wait_out_valid(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (o_out_valid !== 1'b1 && n < limit);
    if (o_out_valid !== 1'b1) begin
      report_error("no output bit appeared while the job was running");
    end
  endtask

  task automatic pulse_start(input int img, input int ker);
    @(posedge clk);
    i_start <= 1'b1;
    i_img_idx <= IMG_IDX_W'(img);
    i_ker_idx <= KER_IDX_W'(ker);
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  // poke pulses a second start in the middle of the job
  task automatic run_job(input int img, input int ker, input bit poke);
    int base;
    for (int br = 0; br < BLK_SIDE; br++) begin
      for (int bc = 0; bc < BLK_SIDE; bc++) begin
        exp_q.push_back(pooled_max(img, ker, br, bc));
      end
    end
    base = res_seen;
    pulse_start(img, ker);
    wait_busy(1'b1, 4);
    if (poke) begin
      wait_out_valid(BUSY_LIMIT);
      pulse_start(IMG_COUNT - 1 - img, KER_COUNT - 1 - ker);
    end
    wait_busy(1'b0, BUSY_LIMIT);
    check_eq("results per job", res_seen - base, POOLS);
    check_eq("o_out_valid", o_out_valid, 0);
    check_eq("pending results", exp_q.size(), 0);
  endtask

  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_eq("o_busy", o_busy, 0);
      check_eq("o_out_valid", o_out_valid, 0);
    end
  endtask

  // collect serial results lsb first
  initial begin
    forever begin
      @(negedge clk);
      if (o_out_valid === 1'b1) begin
        rx_word = {o_out_value, rx_word[RES_W-1:1]};
        rx_bits++;
        run_len++;
        if (rx_bits == RES_W) begin
          if (exp_q.size() == 0) begin
            report_error("a result came out that no job was expected to produce");
          end else begin
            check_eq("o_out_value result", rx_word, exp_q.pop_front());
            res_seen++;
            rx_bits = 0;
          end
        end
      end else if (run_len != 0) begin
        check_eq("o_out_valid run length", run_len, RES_W);
        run_len = 0;
      end
    end
  end

  initial begin
    lfsr = 16'd58;
    rx_word = '0;
    rx_bits = 0;
    run_len = 0;
    res_seen = 0;
    rst_n = 1'b0;
    i_in_valid = 1'b0;
    i_matrix = '0;
    i_start = 1'b0;
    i_img_idx = '0;
    i_ker_idx = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("o_busy", o_busy, 0);
    check_eq("o_out_valid", o_out_valid, 0);
    check_eq("o_out_value", o_out_value, 0);

    load_operands(0);
    run_job(0, 0, 1'b0);

    // fresh load and then every pairing back to back
    load_operands(0);
    for (int m = 0; m < IMG_COUNT; m++) begin
      for (int k = 0; k < KER_COUNT; k++) begin
        run_job(m, k, 1'b0);
      end
    end

    run_job(IMG_COUNT - 1, 0, 1'b1);
    idle_check(40);

    // signed extremes
    load_operands(1);
    run_job(0, KER_COUNT - 1, 1'b0);
    load_operands(2);
    run_job(IMG_COUNT - 1, 0, 1'b0);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/cad_pkg.sv
verilog/operand_store.sv
verilog/window_sequencer.sv
verilog/mac_pool.sv
verilog/result_serializer.sv
verilog/cad_top.sv
verif/tb_cad.sv

// ==== verilog/cad_pkg.sv ====
package cad_pkg;

  // element and arithmetic widths
  localparam int DATA_W = 8;
  localparam int PROD_W = 16;
  localparam int ACC_W = 20;

  // kernel geometry
  localparam int KER_SIDE = 5;
  localparam int KER_TAPS = KER_SIDE * KER_SIDE;

  // max-pool window
  localparam int POOL_SIDE = 2;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// ==== verilog/cad_top.sv ====
`timescale 1ns/10ps

module cad_top #(
  parameter int IMG_SIDE = 8,
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_IDX_W = (IMG_COUNT > 1) ? $clog2(IMG_COUNT) : 1,
  localparam int KER_IDX_W = (KER_COUNT > 1) ? $clog2(KER_COUNT) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_in_valid,
  input  cad_pkg::data_t       i_matrix,
  input  logic                 i_start,
  input  logic [IMG_IDX_W-1:0] i_img_idx,
  input  logic [KER_IDX_W-1:0] i_ker_idx,
  output logic                 o_busy,
  output logic                 o_out_valid,
  output logic                 o_out_value
);

  localparam int POS_W = $clog2(IMG_SIDE);

  logic [IMG_IDX_W-1:0] img_sel;
  logic [KER_IDX_W-1:0] ker_sel;
  logic [POS_W-1:0] row;
  logic [POS_W-1:0] col;
  logic [2:0] tap_r;
  logic [2:0] tap_c;
  cad_pkg::data_t ker_val;
  cad_pkg::data_t pix_00;
  cad_pkg::data_t pix_01;
  cad_pkg::data_t pix_10;
  cad_pkg::data_t pix_11;
  logic acc_clear;
  logic acc_en;
  logic block_done;
  cad_pkg::acc_t res;
  logic res_valid;
  logic last_bit;

  operand_store #(
    .IMG_SIDE (IMG_SIDE),
    .IMG_COUNT(IMG_COUNT),
    .KER_COUNT(KER_COUNT)
  ) u_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_in_valid(i_in_valid),
    .i_matrix  (i_matrix),
    .i_img_sel (img_sel),
    .i_ker_sel (ker_sel),
    .i_row     (row),
    .i_col     (col),
    .i_tap_r   (tap_r),
    .i_tap_c   (tap_c),
    .o_ker_val (ker_val),
    .o_pix_00  (pix_00),
    .o_pix_01  (pix_01),
    .o_pix_10  (pix_10),
    .o_pix_11  (pix_11)
  );

  window_sequencer #(
    .IMG_SIDE (IMG_SIDE),
    .IMG_COUNT(IMG_COUNT),
    .KER_COUNT(KER_COUNT)
  ) u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_img_idx   (i_img_idx),
    .i_ker_idx   (i_ker_idx),
    .i_last_bit  (last_bit),
    .o_busy      (o_busy),
    .o_img_sel   (img_sel),
    .o_ker_sel   (ker_sel),
    .o_row       (row),
    .o_col       (col),
    .o_tap_r     (tap_r),
    .o_tap_c     (tap_c),
    .o_acc_clear (acc_clear),
    .o_acc_en    (acc_en),
    .o_block_done(block_done)
  );

  mac_pool u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_ker_val   (ker_val),
    .i_pix_00    (pix_00),
    .i_pix_01    (pix_01),
    .i_pix_10    (pix_10),
    .i_pix_11    (pix_11),
    .i_acc_clear (acc_clear),
    .i_acc_en    (acc_en),
    .i_block_done(block_done),
    .o_res       (res),
    .o_res_valid (res_valid)
  );

  result_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_res      (res),
    .i_res_valid(res_valid),
    .o_out_valid(o_out_valid),
    .o_out_value(o_out_value),
    .o_last_bit (last_bit)
  );

endmodule

// ==== verilog/mac_pool.sv ====
`timescale 1ns/10ps

module mac_pool (
  input  logic           clk,
  input  logic           rst_n,
  input  cad_pkg::data_t i_ker_val,
  input  cad_pkg::data_t i_pix_00,
  input  cad_pkg::data_t i_pix_01,
  input  cad_pkg::data_t i_pix_10,
  input  cad_pkg::data_t i_pix_11,
  input  logic           i_acc_clear,
  input  logic           i_acc_en,
  input  logic           i_block_done,
  output cad_pkg::acc_t  o_res,
  output logic           o_res_valid
);

  localparam int LANES = cad_pkg::POOL_SIDE * cad_pkg::POOL_SIDE;

  cad_pkg::data_t pix[LANES];
  cad_pkg::acc_t acc[LANES];
  cad_pkg::acc_t sum_q[LANES];
  cad_pkg::acc_t max_top;
  cad_pkg::acc_t max_bot;
  logic sum_valid;

  function automatic cad_pkg::acc_t max2(input cad_pkg::acc_t a, input cad_pkg::acc_t b);
    return (a > b) ? a : b;
  endfunction

  // lane order follows the pool window with the top row first
  assign pix[0] = i_pix_00;
  assign pix[1] = i_pix_01;
  assign pix[2] = i_pix_10;
  assign pix[3] = i_pix_11;

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    logic signed [cad_pkg::PROD_W-1:0] prod;

    assign prod = i_ker_val * pix[g];

    always_ff @(posedge clk) begin
      if (i_acc_clear) begin
        acc[g] <= '0;
      end else if (i_acc_en) begin
        acc[g] <= acc[g] + cad_pkg::acc_t'(prod);
      end
    end

    // snapshot before the next block clears the lane
    always_ff @(posedge clk) begin
      if (i_block_done) begin
        sum_q[g] <= acc[g];
      end
    end
  end

  assign max_top = max2(sum_q[0], sum_q[1]);
  assign max_bot = max2(sum_q[2], sum_q[3]);

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      o_res <= max2(max_top, max_bot);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
      o_res_valid <= 1'b0;
    end else begin
      sum_valid <= i_block_done;
      o_res_valid <= sum_valid;
    end
  end

endmodule

// ==== verilog/operand_store.sv ====
`timescale 1ns/10ps

module operand_store #(
  parameter int IMG_SIDE = 8,
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_IDX_W = (IMG_COUNT > 1) ? $clog2(IMG_COUNT) : 1,
  localparam int KER_IDX_W = (KER_COUNT > 1) ? $clog2(KER_COUNT) : 1,
  localparam int POS_W = $clog2(IMG_SIDE)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_in_valid,
  input  cad_pkg::data_t       i_matrix,
  input  logic [IMG_IDX_W-1:0] i_img_sel,
  input  logic [KER_IDX_W-1:0] i_ker_sel,
  input  logic [POS_W-1:0]     i_row,
  input  logic [POS_W-1:0]     i_col,
  input  logic [2:0]           i_tap_r,
  input  logic [2:0]           i_tap_c,
  output cad_pkg::data_t       o_ker_val,
  output cad_pkg::data_t       o_pix_00,
  output cad_pkg::data_t       o_pix_01,
  output cad_pkg::data_t       o_pix_10,
  output cad_pkg::data_t       o_pix_11
);

  localparam int IMG_SZ = IMG_SIDE * IMG_SIDE;
  localparam int IMG_ELEMS = IMG_COUNT * IMG_SZ;
  localparam int KER_ELEMS = KER_COUNT * cad_pkg::KER_TAPS;
  localparam int TOTAL = IMG_ELEMS + KER_ELEMS;
  localparam int WR_W = $clog2(TOTAL);
  localparam int IMG_AW = $clog2(IMG_ELEMS);
  localparam int KER_AW = $clog2(KER_ELEMS);

  // images back to back, row-major, then kernels likewise
  cad_pkg::data_t img_mem[IMG_ELEMS];
  cad_pkg::data_t ker_mem[KER_ELEMS];

  logic [WR_W-1:0] wr_cnt;
  logic [WR_W-1:0] ker_wr;
  logic [POS_W-1:0] win_r;
  logic [POS_W-1:0] win_c;
  logic [IMG_AW-1:0] pix_base;
  logic [KER_AW-1:0] ker_addr;

  // load position that wraps for the next load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
    end else if (i_in_valid) begin
      if (wr_cnt == WR_W'(TOTAL - 1)) begin
        wr_cnt <= '0;
      end else begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  assign ker_wr = wr_cnt - WR_W'(IMG_ELEMS);

  always_ff @(posedge clk) begin
    if (i_in_valid) begin
      if (wr_cnt < WR_W'(IMG_ELEMS)) begin
        img_mem[IMG_AW'(wr_cnt)] <= i_matrix;
      end else begin
        ker_mem[KER_AW'(ker_wr)] <= i_matrix;
      end
    end
  end

  // top-left pixel of the current tap
  assign win_r = i_row + POS_W'(i_tap_r);
  assign win_c = i_col + POS_W'(i_tap_c);
  assign pix_base = IMG_AW'(i_img_sel) * IMG_AW'(IMG_SZ)
                  + IMG_AW'(win_r) * IMG_AW'(IMG_SIDE)
                  + IMG_AW'(win_c);

  assign ker_addr = KER_AW'(i_ker_sel) * KER_AW'(cad_pkg::KER_TAPS)
                  + KER_AW'(i_tap_r) * KER_AW'(cad_pkg::KER_SIDE)
                  + KER_AW'(i_tap_c);

  assign o_ker_val = ker_mem[ker_addr];
  assign o_pix_00 = img_mem[pix_base];
  assign o_pix_01 = img_mem[pix_base + IMG_AW'(1)];
  assign o_pix_10 = img_mem[pix_base + IMG_AW'(IMG_SIDE)];
  assign o_pix_11 = img_mem[pix_base + IMG_AW'(IMG_SIDE + 1)];

endmodule

// ==== verilog/result_serializer.sv ====
`timescale 1ns/10ps

module result_serializer (
  input  logic          clk,
  input  logic          rst_n,
  input  cad_pkg::acc_t i_res,
  input  logic          i_res_valid,
  output logic          o_out_valid,
  output logic          o_out_value,
  output logic          o_last_bit
);

  localparam int CNT_W = $clog2(cad_pkg::ACC_W);

  logic [cad_pkg::ACC_W-1:0] shreg;
  logic [CNT_W-1:0] cnt;

  // bits still to send after the one on the output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_out_valid <= 1'b0;
      o_out_value <= 1'b0;
      cnt <= '0;
    end else if (i_res_valid) begin
      o_out_valid <= 1'b1;
      o_out_value <= i_res[0];
      cnt <= CNT_W'(cad_pkg::ACC_W - 1);
    end else if (cnt != '0) begin
      o_out_value <= shreg[0];
      cnt <= cnt - 1'b1;
    end else begin
      o_out_valid <= 1'b0;
      o_out_value <= 1'b0;
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (i_res_valid) begin
      shreg <= i_res >> 1;
    end else if (cnt != '0) begin
      shreg <= shreg >> 1;
    end
  end

  assign o_last_bit = o_out_valid && (cnt == '0);

  // the MAC spacing must leave room for a full result
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    i_res_valid |-> (cnt == '0))
    else $error("result arrived during a shift");

endmodule

// ==== verilog/window_sequencer.sv ====
`timescale 1ns/10ps

module window_sequencer #(
  parameter int IMG_SIDE = 8,
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_IDX_W = (IMG_COUNT > 1) ? $clog2(IMG_COUNT) : 1,
  localparam int KER_IDX_W = (KER_COUNT > 1) ? $clog2(KER_COUNT) : 1,
  localparam int POS_W = $clog2(IMG_SIDE)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_start,
  input  logic [IMG_IDX_W-1:0] i_img_idx,
  input  logic [KER_IDX_W-1:0] i_ker_idx,
  input  logic                 i_last_bit,
  output logic                 o_busy,
  output logic [IMG_IDX_W-1:0] o_img_sel,
  output logic [KER_IDX_W-1:0] o_ker_sel,
  output logic [POS_W-1:0]     o_row,
  output logic [POS_W-1:0]     o_col,
  output logic [2:0]           o_tap_r,
  output logic [2:0]           o_tap_c,
  output logic                 o_acc_clear,
  output logic                 o_acc_en,
  output logic                 o_block_done
);

  localparam int CONV_SIDE = IMG_SIDE - cad_pkg::KER_SIDE + 1;
  localparam int BLK_SIDE = CONV_SIDE / cad_pkg::POOL_SIDE;
  localparam int POOLS = BLK_SIDE * BLK_SIDE;
  localparam int LAST_ORG = CONV_SIDE - cad_pkg::POOL_SIDE;
  localparam int CNT_W = $clog2(POOLS + 1);
  localparam logic [2:0] TAP_LAST = 3'(cad_pkg::KER_SIDE - 1);

  logic run;
  logic in_clear;
  logic [CNT_W-1:0] res_cnt;
  logic start_ok;
  logic last_tap;
  logic last_blk;

  assign start_ok = i_start && !o_busy;
  assign last_tap = (o_tap_r == TAP_LAST) && (o_tap_c == TAP_LAST);
  assign last_blk = (o_row == POS_W'(LAST_ORG)) && (o_col == POS_W'(LAST_ORG));

  // one clear cycle and then one enable per tap
  assign o_acc_clear = run && in_clear;
  assign o_acc_en = run && !in_clear;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_img_sel <= '0;
      o_ker_sel <= '0;
    end else if (start_ok) begin
      o_img_sel <= i_img_idx;
      o_ker_sel <= i_ker_idx;
    end
  end

  // busy lasts until the last pooled result has left the serializer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_busy <= 1'b0;
      res_cnt <= '0;
    end else if (start_ok) begin
      o_busy <= 1'b1;
      res_cnt <= '0;
    end else if (i_last_bit) begin
      res_cnt <= res_cnt + 1'b1;
      if (res_cnt == CNT_W'(POOLS - 1)) begin
        o_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
      in_clear <= 1'b0;
      o_tap_r <= '0;
      o_tap_c <= '0;
      o_row <= '0;
      o_col <= '0;
      o_block_done <= 1'b0;
    end else begin
      o_block_done <= 1'b0;
      if (start_ok) begin
        run <= 1'b1;
        in_clear <= 1'b1;
        o_tap_r <= '0;
        o_tap_c <= '0;
        o_row <= '0;
        o_col <= '0;
      end else if (run && in_clear) begin
        in_clear <= 1'b0;
      end else if (run) begin
        if (last_tap) begin
          o_tap_r <= '0;
          o_tap_c <= '0;
          in_clear <= 1'b1;
          o_block_done <= 1'b1;
          // next pool block in raster order
          if (last_blk) begin
            run <= 1'b0;
          end else if (o_col == POS_W'(LAST_ORG)) begin
            o_col <= '0;
            o_row <= o_row + POS_W'(cad_pkg::POOL_SIDE);
          end else begin
            o_col <= o_col + POS_W'(cad_pkg::POOL_SIDE);
          end
        end else if (o_tap_c == TAP_LAST) begin
          o_tap_c <= '0;
          o_tap_r <= o_tap_r + 1'b1;
        end else begin
          o_tap_c <= o_tap_c + 1'b1;
        end
      end
    end
  end

  // the raster never outlives busy so no start can cut into a running job
  a_run_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    run |-> o_busy)
    else $error("block raster running while not busy");

  a_tap_range: assert property (@(posedge clk) disable iff (!rst_n)
    o_acc_en |-> (o_tap_r <= TAP_LAST) && (o_tap_c <= TAP_LAST))
    else $error("tap index out of kernel");

endmodule
